// ==== logic/sim_bus_config.svh ====
// ---------------------------------------------------------
// Bus widths, RAM size and device address map macros
// ---------------------------------------------------------
`ifndef SIM_BUS_CONFIG_SVH
`define SIM_BUS_CONFIG_SVH

// Data and address width
`define SB_DATA_W 32

// RAM size in bytes
`define SB_RAM_BYTES 4096

// 4 KB RAM region at the bottom of the map
`define SB_RAM_BASE 32'h0000_0000
`define SB_RAM_MASK 32'hFFFF_F000

// 1 KB test utility region
`define SB_UTIL_BASE 32'h0002_0000
`define SB_UTIL_MASK 32'hFFFF_FC00

// Test utility register offsets
`define SB_UTIL_SIG_OFS 32'h0000_0000
`define SB_UTIL_HALT_OFS 32'h0000_0004

`endif

// ==== logic/sim_bus_pkg.sv ====
// ---------------------------------------------------------
// Host and device enums, array sizes and bus word types
// ---------------------------------------------------------
`default_nettype none

`include "sim_bus_config.svh"

package sim_bus_pkg;

  // Data host takes priority in the crossbar
  typedef enum logic {
    HostInstr = 1'b0,
    HostData  = 1'b1
  } bus_host_e;

  typedef enum logic {
    DevRam  = 1'b0,
    DevUtil = 1'b1
  } bus_device_e;

  localparam int NR_HOSTS   = 2;
  localparam int NR_DEVICES = 2;

  typedef logic [`SB_DATA_W-1:0]   word_t;
  typedef logic [`SB_DATA_W/8-1:0] be_t;

endpackage

`default_nettype wire

// ==== logic/bus_addr_decode.sv ====
// ---------------------------------------------------------
// Address decoder, one host address to a device select
// ---------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "sim_bus_config.svh"

module bus_addr_decode (
  input  sim_bus_pkg::word_t       addr_i,
  output sim_bus_pkg::bus_device_e dev_sel_o,
  output logic                     miss_o
);

  logic hit_ram;
  logic hit_util;

  // Region match on the masked address
  assign hit_ram  = (addr_i & `SB_RAM_MASK) == `SB_RAM_BASE;
  assign hit_util = (addr_i & `SB_UTIL_MASK) == `SB_UTIL_BASE;

  always_comb begin
    dev_sel_o = sim_bus_pkg::DevRam;
    miss_o    = 1'b1;
    if (hit_ram) begin
      dev_sel_o = sim_bus_pkg::DevRam;
      miss_o    = 1'b0;
    end else if (hit_util) begin
      dev_sel_o = sim_bus_pkg::DevUtil;
      miss_o    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bus_xbar.sv ====
// ---------------------------------------------------------
// Two-host crossbar, fixed priority and response routing
// ---------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module bus_xbar (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     host_req_i    [sim_bus_pkg::NR_HOSTS],
  input  sim_bus_pkg::word_t       host_addr_i   [sim_bus_pkg::NR_HOSTS],
  input  logic                     host_we_i     [sim_bus_pkg::NR_HOSTS],
  input  sim_bus_pkg::be_t         host_be_i     [sim_bus_pkg::NR_HOSTS],
  input  sim_bus_pkg::word_t       host_wdata_i  [sim_bus_pkg::NR_HOSTS],
  output logic                     host_gnt_o    [sim_bus_pkg::NR_HOSTS],
  output logic                     host_rvalid_o [sim_bus_pkg::NR_HOSTS],
  output sim_bus_pkg::word_t       host_rdata_o  [sim_bus_pkg::NR_HOSTS],
  output logic                     host_err_o    [sim_bus_pkg::NR_HOSTS],

  output logic                     dev_req_o     [sim_bus_pkg::NR_DEVICES],
  output sim_bus_pkg::word_t       dev_addr_o    [sim_bus_pkg::NR_DEVICES],
  output logic                     dev_we_o      [sim_bus_pkg::NR_DEVICES],
  output sim_bus_pkg::be_t         dev_be_o      [sim_bus_pkg::NR_DEVICES],
  output sim_bus_pkg::word_t       dev_wdata_o   [sim_bus_pkg::NR_DEVICES],
  input  logic                     dev_rvalid_i  [sim_bus_pkg::NR_DEVICES],
  input  sim_bus_pkg::word_t       dev_rdata_i   [sim_bus_pkg::NR_DEVICES],
  input  logic                     dev_err_i     [sim_bus_pkg::NR_DEVICES]
);

  sim_bus_pkg::bus_device_e host_dev  [sim_bus_pkg::NR_HOSTS];
  logic                     host_miss [sim_bus_pkg::NR_HOSTS];

  sim_bus_pkg::bus_host_e   win_host;
  logic                     win_req;

  // Response bookkeeping for the request granted last cycle
  logic                     rsp_pend_q;
  sim_bus_pkg::bus_host_e   rsp_host_q;
  sim_bus_pkg::bus_device_e rsp_dev_q;
  logic                     rsp_miss_q;

  logic                     rsp_valid;
  sim_bus_pkg::word_t       rsp_data;
  logic                     rsp_err;

  for (genvar h = 0; h < sim_bus_pkg::NR_HOSTS; h++) begin : g_decode
    bus_addr_decode i_decode (
      .addr_i    (host_addr_i[h]),
      .dev_sel_o (host_dev[h]),
      .miss_o    (host_miss[h])
    );
  end

  // Data host first, instruction host otherwise
  always_comb begin
    if (host_req_i[sim_bus_pkg::HostData]) begin
      win_host = sim_bus_pkg::HostData;
    end else begin
      win_host = sim_bus_pkg::HostInstr;
    end
  end

  assign win_req = host_req_i[win_host];

  for (genvar h = 0; h < sim_bus_pkg::NR_HOSTS; h++) begin : g_host
    assign host_gnt_o[h] = win_req && (win_host == sim_bus_pkg::bus_host_e'(h));
  end

  // Winner fields go to every device, only the selected one sees req
  for (genvar d = 0; d < sim_bus_pkg::NR_DEVICES; d++) begin : g_dev
    assign dev_req_o[d]   = win_req && !host_miss[win_host] &&
                            (host_dev[win_host] == sim_bus_pkg::bus_device_e'(d));
    assign dev_addr_o[d]  = host_addr_i[win_host];
    assign dev_we_o[d]    = host_we_i[win_host];
    assign dev_be_o[d]    = host_be_i[win_host];
    assign dev_wdata_o[d] = host_wdata_i[win_host];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_pend_q <= 1'b0;
      rsp_host_q <= sim_bus_pkg::HostInstr;
      rsp_dev_q  <= sim_bus_pkg::DevRam;
      rsp_miss_q <= 1'b0;
    end else begin
      rsp_pend_q <= win_req;
      if (win_req) begin
        rsp_host_q <= win_host;
        rsp_dev_q  <= host_dev[win_host];
        rsp_miss_q <= host_miss[win_host];
      end
    end
  end

  // A miss gets a locally made error response
  assign rsp_valid = rsp_pend_q && (rsp_miss_q || dev_rvalid_i[rsp_dev_q]);
  assign rsp_data  = rsp_miss_q ? '0 : dev_rdata_i[rsp_dev_q];
  assign rsp_err   = rsp_miss_q || dev_err_i[rsp_dev_q];

  for (genvar h = 0; h < sim_bus_pkg::NR_HOSTS; h++) begin : g_rsp
    assign host_rvalid_o[h] = rsp_valid && (rsp_host_q == sim_bus_pkg::bus_host_e'(h));
    assign host_rdata_o[h]  = (rsp_host_q == sim_bus_pkg::bus_host_e'(h)) ? rsp_data : '0;
    assign host_err_o[h]    = host_rvalid_o[h] && rsp_err;
  end

endmodule

`default_nettype wire

// ==== logic/ram_1p.sv ====
// ---------------------------------------------------------
// Single-port word RAM with byte enables
// ---------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "sim_bus_config.svh"

module ram_1p (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  logic               we_i,
  input  sim_bus_pkg::be_t   be_i,
  input  sim_bus_pkg::word_t addr_i,
  input  sim_bus_pkg::word_t wdata_i,
  output logic               rvalid_o,
  output sim_bus_pkg::word_t rdata_o
);

  localparam int DEPTH = `SB_RAM_BYTES / 4;
  localparam int IDX_W = $clog2(DEPTH);

  sim_bus_pkg::word_t mem [DEPTH];
  logic [IDX_W-1:0]   word_idx;

  // Byte address to word index
  assign word_idx = addr_i[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(sim_bus_pkg::be_t); b++) begin
          if (be_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // Old contents are returned on a write too
      rdata_o <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/test_util.sv ====
// ---------------------------------------------------------
// Test utility device, signature stream and halt register
// ---------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "sim_bus_config.svh"

module test_util (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  logic               we_i,
  input  sim_bus_pkg::be_t   be_i,
  input  sim_bus_pkg::word_t addr_i,
  input  sim_bus_pkg::word_t wdata_i,
  output logic               rvalid_o,
  output sim_bus_pkg::word_t rdata_o,
  output logic               err_o,
  output logic               sig_valid_o,
  output sim_bus_pkg::word_t sig_data_o,
  output logic               halt_o,
  output sim_bus_pkg::word_t halt_code_o
);

  sim_bus_pkg::word_t reg_ofs;
  sim_bus_pkg::word_t sig_count_q;
  logic               is_sig;
  logic               is_halt;
  logic               bad_access;
  logic               sig_wr;
  logic               halt_wr;

  assign reg_ofs    = addr_i & ~`SB_UTIL_MASK;
  assign is_sig     = reg_ofs == `SB_UTIL_SIG_OFS;
  assign is_halt    = reg_ofs == `SB_UTIL_HALT_OFS;
  // Only full words at the two known offsets
  assign bad_access = (be_i != '1) || !(is_sig || is_halt);
  assign sig_wr     = req_i && we_i && !bad_access && is_sig;
  assign halt_wr    = req_i && we_i && !bad_access && is_halt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o    <= 1'b0;
      err_o       <= 1'b0;
      sig_valid_o <= 1'b0;
      sig_count_q <= '0;
      halt_o      <= 1'b0;
    end else begin
      rvalid_o    <= req_i;
      err_o       <= req_i && bad_access;
      sig_valid_o <= sig_wr;
      if (sig_wr) begin
        sig_count_q <= sig_count_q + 1'b1;
      end
      // Sticky until reset
      if (halt_wr) begin
        halt_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= (!we_i && !bad_access) ? sig_count_q : '0;
    end
    if (sig_wr) begin
      sig_data_o <= wdata_i;
    end
    if (halt_wr) begin
      halt_code_o <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/compliance_top.sv ====
// ---------------------------------------------------------
// Top level with crossbar, RAM and test utility
// ---------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module compliance_top (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               instr_req_i,
  input  sim_bus_pkg::word_t instr_addr_i,
  output logic               instr_gnt_o,
  output logic               instr_rvalid_o,
  output sim_bus_pkg::word_t instr_rdata_o,
  output logic               instr_err_o,

  input  logic               data_req_i,
  input  logic               data_we_i,
  input  sim_bus_pkg::be_t   data_be_i,
  input  sim_bus_pkg::word_t data_addr_i,
  input  sim_bus_pkg::word_t data_wdata_i,
  output logic               data_gnt_o,
  output logic               data_rvalid_o,
  output sim_bus_pkg::word_t data_rdata_o,
  output logic               data_err_o,

  output logic               sig_valid_o,
  output sim_bus_pkg::word_t sig_data_o,
  output logic               halt_o,
  output sim_bus_pkg::word_t halt_code_o
);

  logic               host_req    [sim_bus_pkg::NR_HOSTS];
  sim_bus_pkg::word_t host_addr   [sim_bus_pkg::NR_HOSTS];
  logic               host_we     [sim_bus_pkg::NR_HOSTS];
  sim_bus_pkg::be_t   host_be     [sim_bus_pkg::NR_HOSTS];
  sim_bus_pkg::word_t host_wdata  [sim_bus_pkg::NR_HOSTS];
  logic               host_gnt    [sim_bus_pkg::NR_HOSTS];
  logic               host_rvalid [sim_bus_pkg::NR_HOSTS];
  sim_bus_pkg::word_t host_rdata  [sim_bus_pkg::NR_HOSTS];
  logic               host_err    [sim_bus_pkg::NR_HOSTS];

  logic               dev_req     [sim_bus_pkg::NR_DEVICES];
  sim_bus_pkg::word_t dev_addr    [sim_bus_pkg::NR_DEVICES];
  logic               dev_we      [sim_bus_pkg::NR_DEVICES];
  sim_bus_pkg::be_t   dev_be      [sim_bus_pkg::NR_DEVICES];
  sim_bus_pkg::word_t dev_wdata   [sim_bus_pkg::NR_DEVICES];
  logic               dev_rvalid  [sim_bus_pkg::NR_DEVICES];
  sim_bus_pkg::word_t dev_rdata   [sim_bus_pkg::NR_DEVICES];
  logic               dev_err     [sim_bus_pkg::NR_DEVICES];

  // Instruction host only reads full words
  assign host_req[sim_bus_pkg::HostInstr]   = instr_req_i;
  assign host_addr[sim_bus_pkg::HostInstr]  = instr_addr_i;
  assign host_we[sim_bus_pkg::HostInstr]    = 1'b0;
  assign host_be[sim_bus_pkg::HostInstr]    = '1;
  assign host_wdata[sim_bus_pkg::HostInstr] = '0;
  assign instr_gnt_o    = host_gnt[sim_bus_pkg::HostInstr];
  assign instr_rvalid_o = host_rvalid[sim_bus_pkg::HostInstr];
  assign instr_rdata_o  = host_rdata[sim_bus_pkg::HostInstr];
  assign instr_err_o    = host_err[sim_bus_pkg::HostInstr];

  assign host_req[sim_bus_pkg::HostData]   = data_req_i;
  assign host_addr[sim_bus_pkg::HostData]  = data_addr_i;
  assign host_we[sim_bus_pkg::HostData]    = data_we_i;
  assign host_be[sim_bus_pkg::HostData]    = data_be_i;
  assign host_wdata[sim_bus_pkg::HostData] = data_wdata_i;
  assign data_gnt_o    = host_gnt[sim_bus_pkg::HostData];
  assign data_rvalid_o = host_rvalid[sim_bus_pkg::HostData];
  assign data_rdata_o  = host_rdata[sim_bus_pkg::HostData];
  assign data_err_o    = host_err[sim_bus_pkg::HostData];

  // RAM never errors
  assign dev_err[sim_bus_pkg::DevRam] = 1'b0;

  bus_xbar i_bus_xbar (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .dev_req_o     (dev_req),
    .dev_addr_o    (dev_addr),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_wdata_o   (dev_wdata),
    .dev_rvalid_i  (dev_rvalid),
    .dev_rdata_i   (dev_rdata),
    .dev_err_i     (dev_err)
  );

  ram_1p i_ram_1p (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (dev_req[sim_bus_pkg::DevRam]),
    .we_i     (dev_we[sim_bus_pkg::DevRam]),
    .be_i     (dev_be[sim_bus_pkg::DevRam]),
    .addr_i   (dev_addr[sim_bus_pkg::DevRam]),
    .wdata_i  (dev_wdata[sim_bus_pkg::DevRam]),
    .rvalid_o (dev_rvalid[sim_bus_pkg::DevRam]),
    .rdata_o  (dev_rdata[sim_bus_pkg::DevRam])
  );

  test_util i_test_util (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (dev_req[sim_bus_pkg::DevUtil]),
    .we_i        (dev_we[sim_bus_pkg::DevUtil]),
    .be_i        (dev_be[sim_bus_pkg::DevUtil]),
    .addr_i      (dev_addr[sim_bus_pkg::DevUtil]),
    .wdata_i     (dev_wdata[sim_bus_pkg::DevUtil]),
    .rvalid_o    (dev_rvalid[sim_bus_pkg::DevUtil]),
    .rdata_o     (dev_rdata[sim_bus_pkg::DevUtil]),
    .err_o       (dev_err[sim_bus_pkg::DevUtil]),
    .sig_valid_o (sig_valid_o),
    .sig_data_o  (sig_data_o),
    .halt_o      (halt_o),
    .halt_code_o (halt_code_o)
  );

endmodule

`default_nettype wire

// ==== bench/compliance_chk.sv ====
// ---------------------------------------------------------
// Crossbar handshake assertions, bound into bus_xbar
// ---------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module compliance_chk (
  input logic clk_i,
  input logic reset_i,
  input logic host_gnt_i    [sim_bus_pkg::NR_HOSTS],
  input logic host_rvalid_i [sim_bus_pkg::NR_HOSTS]
);

  // One grant per cycle at most
  a_one_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    !(host_gnt_i[sim_bus_pkg::HostInstr] && host_gnt_i[sim_bus_pkg::HostData]))
    else $error("both hosts granted in the same cycle");

  for (genvar h = 0; h < sim_bus_pkg::NR_HOSTS; h++) begin : g_host
    // Response exactly one cycle after the grant
    a_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
      host_gnt_i[h] |=> host_rvalid_i[h])
      else $error("host %0d got no rvalid one cycle after gnt", h);
    a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
      host_rvalid_i[h] |-> $past(host_gnt_i[h]))
      else $error("host %0d got rvalid without a gnt before it", h);
  end

endmodule

bind bus_xbar compliance_chk i_compliance_chk (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .host_gnt_i    (host_gnt_o),
  .host_rvalid_i (host_rvalid_o)
);

`default_nettype wire

// ==== bench/compliance_tb.sv ====
// ---------------------------------------------------------
// Testbench for compliance_top, a stimulus table run in a
// loop with response, signature and halt checks
// ---------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "sim_bus_config.svh"

module compliance_tb;

  // conc marks a data-host row that starts together with the next row
  typedef struct packed {
    logic        host;
    logic        conc;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic        chk_rdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        exp_sig;
    logic        exp_halt;
  } row_t;

  logic        clk;
  logic        reset;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        instr_err;
  logic        data_req;
  logic        data_we;
  logic [3:0]  data_be;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_gnt;
  logic        data_rvalid;
  logic [31:0] data_rdata;
  logic        data_err;
  logic        sig_valid;
  logic [31:0] sig_data;
  logic        halt;
  logic [31:0] halt_code;

  row_t        rows [$];
  logic [31:0] ram_model [logic [31:0]];
  logic [31:0] sig_count;
  logic        halt_exp;
  logic [31:0] halt_code_exp;
  int          cycle_count;
  int          cycle_limit;

  compliance_top i_compliance_top (
    .clk_i          (clk),
    .reset_i        (reset),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .instr_err_o    (instr_err),
    .data_req_i     (data_req),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata),
    .data_err_o     (data_err),
    .sig_valid_o    (sig_valid),
    .sig_data_o     (sig_data),
    .halt_o         (halt),
    .halt_code_o    (halt_code)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run took more than %0d clock cycles", cycle_limit);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  task automatic check_val(string name, logic [31:0] exp_v, logic [31:0] act_v);
    assert (act_v === exp_v) else begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic add_row(logic host, logic conc, logic we, logic [31:0] addr, logic [3:0] be,
                         logic [31:0] wdata, logic chk, logic [31:0] exp_rd, logic err,
                         logic sig, logic hlt);
    rows.push_back({host, conc, we, addr, be, wdata, chk, exp_rd, err, sig, hlt});
  endtask

  // RAM rows keep the reference model up to date
  task automatic ram_wr(logic [31:0] addr, logic [3:0] be, logic [31:0] wdata);
    logic [31:0] old_w;
    old_w = ram_model.exists(addr) ? ram_model[addr] : 32'h0;
    ram_model[addr] = merge_bytes(old_w, wdata, be);
    add_row(sim_bus_pkg::HostData, 1'b0, 1'b1, addr, be, wdata, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic ram_rd(logic host, logic conc, logic [31:0] addr);
    add_row(host, conc, 1'b0, addr, 4'hF, 32'h0, 1'b1, ram_model[addr], 1'b0, 1'b0, 1'b0);
  endtask

  task automatic util_rd(logic host, logic [31:0] addr);
    add_row(host, 1'b0, 1'b0, addr, 4'hF, 32'h0, 1'b1, sig_count, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic build_table();
    logic [31:0] sig_a;
    logic [31:0] halt_a;
    sig_a  = `SB_UTIL_BASE + `SB_UTIL_SIG_OFS;
    halt_a = `SB_UTIL_BASE + `SB_UTIL_HALT_OFS;
    sig_count = 32'h0;
    for (int k = 0; k < 4; k++) begin
      ram_wr(32'h100 + 4 * k, 4'hF, $urandom());
    end
    for (int k = 0; k < 4; k++) begin
      ram_rd((k % 2 == 1) ? sim_bus_pkg::HostData : sim_bus_pkg::HostInstr, 1'b0,
             32'h100 + 4 * k);
    end
    // Partial writes over full words
    ram_wr(32'h104, 4'b0011, $urandom());
    ram_wr(32'h108, 4'b1000, $urandom());
    ram_wr(32'h10C, 4'b0110, $urandom());
    ram_rd(sim_bus_pkg::HostData, 1'b0, 32'h104);
    ram_rd(sim_bus_pkg::HostInstr, 1'b0, 32'h108);
    ram_rd(sim_bus_pkg::HostData, 1'b0, 32'h10C);
    // Both hosts at once
    ram_rd(sim_bus_pkg::HostData, 1'b1, 32'h100);
    ram_rd(sim_bus_pkg::HostInstr, 1'b0, 32'h10C);
    ram_rd(sim_bus_pkg::HostData, 1'b1, 32'h108);
    ram_rd(sim_bus_pkg::HostInstr, 1'b0, 32'h104);
    // Unmapped addresses where 0x1100 would alias RAM word 0x100 if decoded wrong
    add_row(sim_bus_pkg::HostData, 1'b0, 1'b0, 32'h2000, 4'hF, 32'h0,
            1'b1, 32'h0, 1'b1, 1'b0, 1'b0);
    add_row(sim_bus_pkg::HostInstr, 1'b0, 1'b0, 32'h3000_0000, 4'hF, 32'h0,
            1'b1, 32'h0, 1'b1, 1'b0, 1'b0);
    add_row(sim_bus_pkg::HostData, 1'b0, 1'b1, 32'h1100, 4'hF, $urandom(),
            1'b1, 32'h0, 1'b1, 1'b0, 1'b0);
    ram_rd(sim_bus_pkg::HostData, 1'b0, 32'h100);
    // Signature stream
    util_rd(sim_bus_pkg::HostData, sig_a);
    for (int k = 0; k < 3; k++) begin
      add_row(sim_bus_pkg::HostData, 1'b0, 1'b1, sig_a, 4'hF, $urandom(),
              1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
      sig_count = sig_count + 32'h1;
    end
    add_row(sim_bus_pkg::HostData, 1'b0, 1'b1, sig_a, 4'h3, $urandom(),
            1'b0, 32'h0, 1'b1, 1'b0, 1'b0);
    util_rd(sim_bus_pkg::HostData, sig_a);
    util_rd(sim_bus_pkg::HostInstr, halt_a);
    add_row(sim_bus_pkg::HostData, 1'b0, 1'b0, sig_a + 32'h8, 4'hF, 32'h0,
            1'b0, 32'h0, 1'b1, 1'b0, 1'b0);
    // Halt and then more traffic to see it stick
    add_row(sim_bus_pkg::HostData, 1'b0, 1'b1, halt_a, 4'hF, 32'h0000_002A,
            1'b0, 32'h0, 1'b0, 1'b0, 1'b1);
    ram_rd(sim_bus_pkg::HostInstr, 1'b0, 32'h104);
    util_rd(sim_bus_pkg::HostData, sig_a);
  endtask

  task automatic drive_row(row_t r);
    if (r.host == sim_bus_pkg::HostData) begin
      data_req   = 1'b1;
      data_we    = r.we;
      data_be    = r.be;
      data_addr  = r.addr;
      data_wdata = r.wdata;
    end else begin
      instr_req  = 1'b1;
      instr_addr = r.addr;
    end
  endtask

  task automatic release_host(logic host);
    if (host == sim_bus_pkg::HostData) begin
      data_req = 1'b0;
    end else begin
      instr_req = 1'b0;
    end
  endtask

  // Called on the falling edge inside the response cycle
  task automatic check_rsp(row_t r);
    logic        own_rvalid;
    logic        other_rvalid;
    logic [31:0] own_rdata;
    logic        own_err;
    own_rvalid   = r.host ? data_rvalid : instr_rvalid;
    other_rvalid = r.host ? instr_rvalid : data_rvalid;
    own_rdata    = r.host ? data_rdata : instr_rdata;
    own_err      = r.host ? data_err : instr_err;
    check_val(r.host ? "data_rvalid_o" : "instr_rvalid_o", 32'h1, own_rvalid);
    check_val(r.host ? "instr_rvalid_o" : "data_rvalid_o", 32'h0, other_rvalid);
    if (r.chk_rdata) begin
      check_val(r.host ? "data_rdata_o" : "instr_rdata_o", r.exp_rdata, own_rdata);
    end
    check_val(r.host ? "data_err_o" : "instr_err_o", r.exp_err, own_err);
    check_val("sig_valid_o", r.exp_sig, sig_valid);
    if (r.exp_sig) begin
      check_val("sig_data_o", r.wdata, sig_data);
    end
    if (r.exp_halt) begin
      halt_exp      = 1'b1;
      halt_code_exp = r.wdata;
    end
    check_val("halt_o", halt_exp, halt);
    if (halt_exp) begin
      check_val("halt_code_o", halt_code_exp, halt_code);
    end
  endtask

  task automatic run_single(row_t r);
    drive_row(r);
    @(posedge clk);
    while (!(r.host ? data_gnt : instr_gnt)) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_rsp(r);
    release_host(r.host);
  endtask

  // Data host wins the first cycle, instruction host the next
  task automatic run_pair(row_t d, row_t n);
    drive_row(d);
    drive_row(n);
    @(posedge clk);
    check_val("data_gnt_o", 32'h1, data_gnt);
    check_val("instr_gnt_o", 32'h0, instr_gnt);
    @(negedge clk);
    check_rsp(d);
    release_host(d.host);
    @(posedge clk);
    check_val("instr_gnt_o", 32'h1, instr_gnt);
    @(negedge clk);
    check_rsp(n);
    release_host(n.host);
  endtask

  initial begin
    void'($urandom(32'h3588f089));
    reset         = 1'b1;
    instr_req     = 1'b0;
    instr_addr    = 32'h0;
    data_req      = 1'b0;
    data_we       = 1'b0;
    data_be       = 4'h0;
    data_addr     = 32'h0;
    data_wdata    = 32'h0;
    halt_exp      = 1'b0;
    halt_code_exp = 32'h0;
    cycle_count   = 0;
    cycle_limit   = 1000;
    build_table();
    cycle_limit = 5 * rows.size() + 30;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_val("instr_gnt_o", 32'h0, instr_gnt);
    check_val("data_gnt_o", 32'h0, data_gnt);
    check_val("instr_rvalid_o", 32'h0, instr_rvalid);
    check_val("data_rvalid_o", 32'h0, data_rvalid);
    check_val("instr_err_o", 32'h0, instr_err);
    check_val("data_err_o", 32'h0, data_err);
    check_val("sig_valid_o", 32'h0, sig_valid);
    check_val("halt_o", 32'h0, halt);
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].conc && (i + 1 < rows.size())) begin
        run_pair(rows[i], rows[i + 1]);
        i++;
      end else begin
        run_single(rows[i]);
      end
    end
    @(negedge clk);
    check_val("halt_o", 32'h1, halt);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/sim_bus_pkg.sv
logic/bus_addr_decode.sv
logic/bus_xbar.sv
logic/ram_1p.sv
logic/test_util.sv
logic/compliance_top.sv
bench/compliance_chk.sv
bench/compliance_tb.sv

// ==== Makefile ====
# Verilator build and run of the compliance platform testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module compliance_tb \
		-f sources.f --Mdir obj_dir
	./obj_dir/Vcompliance_tb | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf obj_dir
